// ==== hdl/exu_alu.sv ====
`timescale 1ns/100ps

module exu_alu import exu_pkg::*; (
    input  logic [DATA_WIDTH-1:0] src1,
    input  logic [DATA_WIDTH-1:0] src2,
    input  alu_op_e               alu_op,
    output logic [DATA_WIDTH-1:0] alu_result,
    output logic                  branch_less,
    output logic                  branch_zero
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    // compare flags also feed the branch unit
    assign branch_zero = (src1 == src2);
    assign branch_less = (alu_op == ALU_SLTU) ? (src1 < src2)
                                              : ($signed(src1) < $signed(src2));

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                alu_result = src1 + src2;
            end
            ALU_SUB: begin
                alu_result = src1 - src2;
            end
            ALU_AND: begin
                alu_result = src1 & src2;
            end
            ALU_OR: begin
                alu_result = src1 | src2;
            end
            ALU_XOR: begin
                alu_result = src1 ^ src2;
            end
            ALU_SLL: begin
                alu_result = src1 << shamt;
            end
            ALU_SRL: begin
                alu_result = src1 >> shamt;
            end
            ALU_SRA: begin
                alu_result = $signed(src1) >>> shamt;
            end
            // set-less-than reuses the compare flag, signed or unsigned by op
            ALU_SLT, ALU_SLTU: begin
                alu_result = {{(DATA_WIDTH-1){1'b0}}, branch_less};
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

// ==== hdl/exu_bru.sv ====
`timescale 1ns/100ps

module exu_bru import exu_pkg::*; (
    input  branch_op_e            branch_op,
    input  logic                  branch_less,
    input  logic                  branch_zero,
    input  logic [DATA_WIDTH-1:0] branch_pc,
    input  logic [DATA_WIDTH-1:0] branch_rs1,
    input  logic [DATA_WIDTH-1:0] branch_imm,
    output logic                  branch_taken,
    output logic [DATA_WIDTH-1:0] branch_jmp_pc
);

    logic [DATA_WIDTH-1:0] jalr_pc;

    always_comb begin
        case (branch_op)
            BR_JAL, BR_JALR:   branch_taken = 1'b1;
            BR_BEQ:            branch_taken = branch_zero;
            BR_BNE:            branch_taken = !branch_zero;
            BR_BLT, BR_BLTU:   branch_taken = branch_less;
            BR_BGE, BR_BGEU:   branch_taken = !branch_less;
            default:           branch_taken = 1'b0;
        endcase
    end

    // jalr target is rs1 relative with the low bit forced to zero
    assign jalr_pc = (branch_rs1 + branch_imm) & ~{{(DATA_WIDTH-1){1'b0}}, 1'b1};

    always_comb begin
        if (!branch_taken) begin
            branch_jmp_pc = branch_pc + 4;
        end else if (branch_op == BR_JALR) begin
            branch_jmp_pc = jalr_pc;
        end else begin
            branch_jmp_pc = branch_pc + branch_imm;
        end
    end

endmodule

// ==== hdl/exu_lsu.sv ====
`timescale 1ns/100ps

module exu_lsu import exu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    mem_req_if.unit               req,
    input  logic                  wb_ready,

    output logic                  wr_req,
    output logic [DATA_WIDTH-1:0] wr_addr,
    output logic [DATA_WIDTH-1:0] wr_data,
    output logic [STRB_WIDTH-1:0] wr_mask,
    input  logic                  wr_complete,

    output logic                  rd_req,
    output logic [DATA_WIDTH-1:0] rd_addr,
    input  logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  rd_complete
);

    lsu_state_e            state;
    lsu_state_e            state_nxt;
    logic                  ren_q;
    logic                  wen_q;
    logic                  complete;
    logic [DATA_WIDTH-1:0] addr_q;
    logic [OFFS_WIDTH-1:0] offs_q;
    mem_size_e             size_q;
    logic                  sext_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [STRB_WIDTH-1:0] mask_q;
    logic [DATA_WIDTH-1:0] lane_data;
    logic [STRB_WIDTH-1:0] lane_mask;
    logic [DATA_WIDTH-1:0] rd_shift;
    logic [DATA_WIDTH-1:0] load_ext;
    logic [DATA_WIDTH-1:0] load_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request FSM

    assign complete = (ren_q & rd_complete) | (wen_q & wr_complete);

    always_comb begin
        state_nxt = state;
        case (state)
            LSU_IDLE: if (req.valid) state_nxt = LSU_WAIT;
            LSU_WAIT: if (complete) state_nxt = LSU_DONE;
            LSU_DONE: if (wb_ready) state_nxt = LSU_IDLE;
            default:  state_nxt = LSU_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LSU_IDLE;
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == LSU_IDLE && req.valid) begin
                ren_q <= req.ren;
                wen_q <= req.wen;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // store lane alignment

    always_comb begin
        case (req.size)
            SIZE_BYTE: begin
                lane_data = {STRB_WIDTH{req.wdata[7:0]}};
                lane_mask = {{(STRB_WIDTH-1){1'b0}}, 1'b1} << req.addr[OFFS_WIDTH-1:0];
            end
            SIZE_HALF: begin
                lane_data = {(STRB_WIDTH/2){req.wdata[15:0]}};
                lane_mask = {{(STRB_WIDTH-2){1'b0}}, 2'b11} << {req.addr[OFFS_WIDTH-1:1], 1'b0};
            end
            default: begin
                lane_data = req.wdata;
                lane_mask = '1;
            end
        endcase
    end

    // operation is latched on accept so the bus sees stable fields
    always_ff @(posedge clk) begin
        if (state == LSU_IDLE && req.valid) begin
            addr_q  <= {req.addr[DATA_WIDTH-1:OFFS_WIDTH], {OFFS_WIDTH{1'b0}}};
            offs_q  <= req.addr[OFFS_WIDTH-1:0];
            size_q  <= req.size;
            sext_q  <= req.sext;
            wdata_q <= lane_data;
            mask_q  <= lane_mask;
        end
        if (state == LSU_WAIT && ren_q && rd_complete) begin
            load_q <= load_ext;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load extraction

    assign rd_shift = rd_data >> {offs_q, 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: load_ext = {{(DATA_WIDTH-8){sext_q & rd_shift[7]}}, rd_shift[7:0]};
            SIZE_HALF: load_ext = {{(DATA_WIDTH-16){sext_q & rd_shift[15]}}, rd_shift[15:0]};
            default:   load_ext = rd_data;
        endcase
    end

    assign rd_req  = (state == LSU_WAIT) & ren_q;
    assign wr_req  = (state == LSU_WAIT) & wen_q;
    assign rd_addr = addr_q;
    assign wr_addr = addr_q;
    assign wr_data = wdata_q;
    assign wr_mask = mask_q;

    assign req.done  = (state == LSU_DONE);
    assign req.rdata = load_q;

endmodule

// ==== hdl/exu_pkg.sv ====
package exu_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 5;

    // byte lanes on the memory bus and the width of the offset inside a word
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int OFFS_WIDTH = $clog2(STRB_WIDTH);

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_JAL  = 4'd1,
        BR_JALR = 4'd2,
        BR_BEQ  = 4'd3,
        BR_BNE  = 4'd4,
        BR_BLT  = 4'd5,
        BR_BGE  = 4'd6,
        BR_BLTU = 4'd7,
        BR_BGEU = 4'd8
    } branch_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        LSU_IDLE = 2'd0,
        LSU_WAIT = 2'd1,
        LSU_DONE = 2'd2
    } lsu_state_e;

endpackage

// ==== hdl/exu_top.sv ====
`timescale 1ns/100ps

module exu_top import exu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  wb_ready,
    output logic                  out_valid,

    input  logic [DATA_WIDTH-1:0] alu_src1,
    input  logic [DATA_WIDTH-1:0] alu_src2,
    input  alu_op_e               alu_op,
    input  branch_op_e            branch_op,
    input  logic [DATA_WIDTH-1:0] branch_pc,
    input  logic [DATA_WIDTH-1:0] branch_rs1,
    input  logic [DATA_WIDTH-1:0] branch_imm,
    input  logic [ADDR_WIDTH-1:0] rd,

    input  logic                  mem_ren,
    input  logic                  mem_wen,
    input  mem_size_e             mem_size,
    input  logic                  mem_sext,
    input  logic [DATA_WIDTH-1:0] mem_wdata,

    output logic                  reg_wen,
    output logic [ADDR_WIDTH-1:0] reg_waddr,
    output logic [DATA_WIDTH-1:0] reg_wdata,
    output logic                  branch_taken,
    output logic [DATA_WIDTH-1:0] branch_jmp_pc,

    output logic                  wr_req,
    output logic [DATA_WIDTH-1:0] wr_addr,
    output logic [DATA_WIDTH-1:0] wr_data,
    output logic [STRB_WIDTH-1:0] wr_mask,
    input  logic                  wr_complete,

    output logic                  rd_req,
    output logic [DATA_WIDTH-1:0] rd_addr,
    input  logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  rd_complete
);

    logic [DATA_WIDTH-1:0] alu_result;
    logic                  branch_less;
    logic                  branch_zero;
    logic                  is_mem;

    mem_req_if mreq ();

    exu_alu u_alu (
        .src1        (alu_src1),
        .src2        (alu_src2),
        .alu_op      (alu_op),
        .alu_result  (alu_result),
        .branch_less (branch_less),
        .branch_zero (branch_zero)
    );

    exu_bru u_bru (
        .branch_op     (branch_op),
        .branch_less   (branch_less),
        .branch_zero   (branch_zero),
        .branch_pc     (branch_pc),
        .branch_rs1    (branch_rs1),
        .branch_imm    (branch_imm),
        .branch_taken  (branch_taken),
        .branch_jmp_pc (branch_jmp_pc)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory request built from the inputs and the ALU sum

    assign is_mem     = mem_ren | mem_wen;
    assign mreq.valid = in_valid & is_mem;
    assign mreq.ren   = mem_ren;
    assign mreq.wen   = mem_wen;
    assign mreq.addr  = alu_result;
    assign mreq.size  = mem_size;
    assign mreq.sext  = mem_sext;
    assign mreq.wdata = mem_wdata;

    exu_lsu u_lsu (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (mreq.unit),
        .wb_ready    (wb_ready),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_mask     (wr_mask),
        .wr_complete (wr_complete),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_complete (rd_complete)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage handshake and register write port

    assign in_ready  = rst_n & ~mreq.done;
    assign out_valid = in_valid & (is_mem ? mreq.done : 1'b1);

    assign reg_wen   = out_valid & (rd != '0);
    assign reg_waddr = reg_wen ? rd : '0;
    assign reg_wdata = !reg_wen ? '0 : (mem_ren ? mreq.rdata : alu_result);

endmodule

// ==== hdl/mem_req_if.sv ====
`timescale 1ns/100ps

// one load or store handed from the stage to the load/store unit
interface mem_req_if import exu_pkg::*; ();

    logic                  valid;
    logic                  ren;
    logic                  wen;
    logic [DATA_WIDTH-1:0] addr;
    mem_size_e             size;
    logic                  sext;
    logic [DATA_WIDTH-1:0] wdata;
    logic                  done;
    logic [DATA_WIDTH-1:0] rdata;

    modport ctrl (
        output valid, ren, wen, addr, size, sext, wdata,
        input  done, rdata
    );

    modport unit (
        input  valid, ren, wen, addr, size, sext, wdata,
        output done, rdata
    );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and decide the result from the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module exu_tb -f verilog.f -o exu_sim
./obj_dir/exu_sim | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== test/exu_chk.sv ====
`timescale 1ns/100ps

module exu_chk import exu_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  rd_req,
    input logic                  rd_complete,
    input logic [DATA_WIDTH-1:0] rd_addr,
    input logic                  wr_req,
    input logic                  wr_complete,
    input logic [DATA_WIDTH-1:0] wr_addr,
    input logic [DATA_WIDTH-1:0] wr_data,
    input logic [STRB_WIDTH-1:0] wr_mask,
    input logic                  out_valid,
    input logic                  wb_ready,
    input logic                  reg_wen,
    input logic [ADDR_WIDTH-1:0] reg_waddr,
    input logic [DATA_WIDTH-1:0] reg_wdata
);

    // only one memory operation is ever in flight
    req_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rd_req && wr_req))
        else $error("read and write requests are high in the same cycle");

    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_req && !rd_complete) |=> (rd_req && $stable(rd_addr)))
        else $error("read request dropped or changed before completion");

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_req && !wr_complete) |=> (wr_req && $stable(wr_addr) && $stable(wr_data)
                                      && $stable(wr_mask)))
        else $error("write request dropped or changed before completion");

    valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !wb_ready) |=> out_valid)
        else $error("out_valid fell before wb_ready");

    // a stalled register write keeps its address and data
    wen_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (reg_wen && !wb_ready) |=> (reg_wen && $stable(reg_waddr) && $stable(reg_wdata)))
        else $error("register write port changed while wb_ready was low");

endmodule

bind exu_top exu_chk chk0 (.*);

// ==== test/exu_tb.sv ====
`timescale 1ns/100ps

module exu_tb import exu_pkg::*; ();

    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 12;
    localparam int DRIVE_DELAY    = 10;

    logic                  clk, rst_n, in_valid, in_ready, wb_ready, out_valid;
    logic                  mem_ren, mem_wen, mem_sext, reg_wen, branch_taken;
    logic                  wr_req, wr_complete, rd_req, rd_complete;
    logic [DATA_WIDTH-1:0] alu_src1, alu_src2, branch_pc, branch_rs1, branch_imm, mem_wdata;
    logic [DATA_WIDTH-1:0] reg_wdata, branch_jmp_pc, wr_addr, wr_data, rd_addr, rd_data;
    logic [ADDR_WIDTH-1:0] rd, reg_waddr;
    logic [STRB_WIDTH-1:0] wr_mask;
    alu_op_e               alu_op;
    branch_op_e            branch_op;
    mem_size_e             mem_size;

    // reference model state
    logic [DATA_WIDTH-1:0] mem_model [0:63];
    logic [DATA_WIDTH-1:0] exp_result, exp_target, exp_addr, exp_data, r;
    logic [STRB_WIDTH-1:0] exp_mask;
    logic                  exp_taken, is_mem, accepted;
    integer                seed;
    int                    cycles, err_count, mem_latency, lat, op_cycle;

    exu_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model

    function automatic logic [DATA_WIDTH-1:0] alu_model(alu_op_e op,
            logic [DATA_WIDTH-1:0] a, logic [DATA_WIDTH-1:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
            ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'd0, a < b};
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_cond(branch_op_e op,
            logic [DATA_WIDTH-1:0] a, logic [DATA_WIDTH-1:0] b);
        case (op)
            BR_JAL, BR_JALR: return 1'b1;
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [DATA_WIDTH-1:0] load_model(logic [DATA_WIDTH-1:0] word,
            logic [1:0] offs, mem_size_e size, logic sext);
        logic [DATA_WIDTH-1:0] sh;
        sh = word >> {offs, 3'b000};
        case (size)
            SIZE_BYTE: return {{24{sext & sh[7]}}, sh[7:0]};
            SIZE_HALF: return {{16{sext & sh[15]}}, sh[15:0]};
            default:   return word;
        endcase
    endfunction

    function automatic logic [DATA_WIDTH-1:0] lane_bits(logic [STRB_WIDTH-1:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("error: %s is %h, expected %h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and expected values

    task automatic setup_op();
        logic [DATA_WIDTH-1:0] addr;
        r          = $random(seed);
        in_valid   = 1'b1;
        alu_src1   = $random(seed);
        alu_src2   = $random(seed);
        branch_pc  = $random(seed);
        branch_rs1 = $random(seed);
        branch_imm = $random(seed);
        mem_wdata  = $random(seed);
        // equal sources now and then so that BEQ and BNE see both outcomes
        if (r[2:1] == 2'd0) begin
            alu_src2 = alu_src1;
        end
        rd          = (r[5:3] == 3'd0) ? 5'd0 : r[10:6];
        mem_sext    = r[11];
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_size    = SIZE_WORD;
        branch_op   = BR_NONE;
        is_mem      = 1'b0;
        mem_latency = 32'(r[20:19]) + 1;
        case (r[13:12])
            2'd0, 2'd1: begin
                alu_op = alu_op_e'(r[17:14] % 4'd10);
            end
            2'd2: begin
                branch_op = branch_op_e'({1'b0, r[16:14]} + 4'd1);
                alu_op    = (branch_op == BR_BLTU || branch_op == BR_BGEU) ? ALU_SLTU : ALU_SUB;
            end
            default: begin
                is_mem   = 1'b1;
                alu_op   = ALU_ADD;
                mem_size = mem_size_e'(r[15:14] % 2'd3);
                mem_ren  = r[16];
                mem_wen  = !r[16];
                addr     = {24'h0, r[31:24]};
                if (mem_size == SIZE_HALF) begin
                    addr[0] = 1'b0;
                end else if (mem_size == SIZE_WORD) begin
                    addr[1:0] = 2'b00;
                end
                alu_src2 = addr - alu_src1;
            end
        endcase
    endtask

    task automatic compute_expected();
        exp_addr   = alu_model(alu_op, alu_src1, alu_src2);
        exp_result = exp_addr;
        if (mem_ren) begin
            exp_result = load_model(mem_model[exp_addr[7:2]], exp_addr[1:0], mem_size, mem_sext);
        end
        exp_taken  = branch_cond(branch_op, alu_src1, alu_src2);
        if (!exp_taken) begin
            exp_target = branch_pc + 32'd4;
        end else if (branch_op == BR_JALR) begin
            exp_target = (branch_rs1 + branch_imm) & ~32'd1;
        end else begin
            exp_target = branch_pc + branch_imm;
        end
        case (mem_size)
            SIZE_BYTE: exp_mask = 4'b0001 << exp_addr[1:0];
            SIZE_HALF: exp_mask = 4'b0011 << exp_addr[1:0];
            default:   exp_mask = 4'b1111;
        endcase
        case (mem_size)
            SIZE_BYTE: exp_data = {4{mem_wdata[7:0]}};
            SIZE_HALF: exp_data = {2{mem_wdata[15:0]}};
            default:   exp_data = mem_wdata;
        endcase
    endtask

    // sampled at the falling edge, half a cycle after the inputs settle
    task automatic check_cycle();
        logic exp_valid;
        logic exp_wen;
        logic exp_req;
        // a memory operation ends one cycle after the bus slave answers
        exp_valid = in_valid && (!is_mem || op_cycle > mem_latency);
        exp_wen   = exp_valid && (rd != '0);
        exp_req   = in_valid && is_mem && (op_cycle > 0) && (op_cycle <= mem_latency);
        check_value("out_valid", 32'(out_valid), 32'(exp_valid));
        check_value("reg_wen", 32'(reg_wen), 32'(exp_wen));
        check_value("reg_waddr", 32'(reg_waddr), 32'(exp_wen ? rd : 5'd0));
        check_value("reg_wdata", reg_wdata, exp_wen ? exp_result : '0);
        check_value("branch_taken", 32'(branch_taken), 32'(exp_taken));
        check_value("branch_jmp_pc", branch_jmp_pc, exp_target);
        check_value("in_ready", 32'(in_ready), 32'(rst_n && !(is_mem && exp_valid)));
        check_value("rd_req", 32'(rd_req), 32'(exp_req && mem_ren));
        check_value("wr_req", 32'(wr_req), 32'(exp_req && mem_wen));
        if (rd_req) begin
            check_value("rd_addr", rd_addr, {exp_addr[31:2], 2'b00});
        end
        if (wr_req) begin
            check_value("wr_addr", wr_addr, {exp_addr[31:2], 2'b00});
            check_value("wr_mask", 32'(wr_mask), 32'(exp_mask));
            check_value("wr_data", wr_data & lane_bits(exp_mask), exp_data & lane_bits(exp_mask));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus slave that answers after mem_latency cycles

    initial begin
        rd_complete = 1'b0;
        wr_complete = 1'b0;
        rd_data     = '0;
        lat         = -1;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            rd_complete = 1'b0;
            wr_complete = 1'b0;
            if (!rd_req && !wr_req) begin
                lat = -1;
            end else begin
                if (lat < 0) begin
                    lat = mem_latency;
                end
                lat--;
                if (lat == 0 && rd_req) begin
                    rd_data     = mem_model[rd_addr[7:2]];
                    rd_complete = 1'b1;
                end else if (lat == 0) begin
                    mem_model[wr_addr[7:2]] = (mem_model[wr_addr[7:2]] & ~lane_bits(wr_mask))
                                            | (wr_data & lane_bits(wr_mask));
                    wr_complete = 1'b1;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "run timed out");
    end

    initial begin
        seed       = 5593;
        err_count  = 0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        wb_ready   = 1'b0;
        alu_src1   = '0;
        alu_src2   = '0;
        alu_op     = ALU_ADD;
        branch_op  = BR_NONE;
        branch_pc  = '0;
        branch_rs1 = '0;
        branch_imm = '0;
        rd         = '0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_size   = SIZE_WORD;
        mem_sext   = 1'b0;
        mem_wdata  = '0;
        is_mem     = 1'b0;
        op_cycle   = 0;
        for (int i = 0; i < 64; i++) begin
            mem_model[i] = (i * 32'h01F3_5A27) ^ 32'hC3A5_0F1E;
        end
        compute_expected();
        @(negedge clk);
        check_cycle();
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        for (int n = 0; n < NUM_OPS; n++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                in_valid = 1'b0;
                is_mem   = 1'b0;
                @(negedge clk);
                check_cycle();
                @(posedge clk);
                #DRIVE_DELAY;
            end
            setup_op();
            compute_expected();
            op_cycle   = 0;
            accepted   = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                check_cycle();
                accepted = out_valid && wb_ready;
                op_cycle++;
                @(posedge clk);
                #DRIVE_DELAY;
                r        = $random(seed);
                wb_ready = (r[1:0] != 2'd0);
            end
        end

        in_valid = 1'b0;
        is_mem   = 1'b0;
        @(negedge clk);
        check_cycle();
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/exu_pkg.sv
hdl/mem_req_if.sv
hdl/exu_alu.sv
hdl/exu_bru.sv
hdl/exu_lsu.sv
hdl/exu_top.sv
test/exu_chk.sv
test/exu_tb.sv
